//--- hw/ingress_pkg.sv
`default_nettype none

package ingress_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Word and length types

	typedef logic [63:0] data_word_t;
	typedef logic [71:0] code_word_t;
	typedef logic [10:0] bytelen_t;
	typedef logic [7:0]  wordlen_t;

	localparam int WORD_BYTES = 8;

	////////////////////////////////////////////////////////////////////////////
	// SECDED (72,64) layout

	// SRAM word is {parity, check[6:0], data[63:0]}
	localparam int HAM_BITS = 7;
	localparam int PAR_POS  = 71;

	// Hamming position of data bit idx, skipping the power-of-two slots
	function automatic int unsigned ham_pos(input int unsigned idx);
		int unsigned pos;
		int unsigned cnt;
		pos = 0;
		cnt = 0;
		for (int unsigned p = 3; p <= PAR_POS; p++) begin
			if ((p & (p - 1)) != 0) begin
				if (cnt == idx)
					pos = p;
				cnt++;
			end
		end
		return pos;
	endfunction

	// Check bit k covers every data bit whose position has bit k set
	function automatic logic [HAM_BITS-1:0] ham_check(input data_word_t d);
		logic [HAM_BITS-1:0] chk;
		int unsigned pos;
		chk = '0;
		for (int j = 0; j < $bits(data_word_t); j++) begin
			pos = ham_pos(j);
			for (int k = 0; k < HAM_BITS; k++) begin
				if (pos[k])
					chk[k] = chk[k] ^ d[j];
			end
		end
		return chk;
	endfunction

endpackage

`default_nettype wire

//--- hw/ecc_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_encoder import ingress_pkg::*; (
	input wire clk_ram_ctl,
	input wire arst_n,
	input wire data_word_t enc_data,
	output code_word_t code
);

	logic [HAM_BITS-1:0] chk;
	code_word_t code_next;

	assign chk = ham_check(enc_data);

	// Assemble {parity, check, data}
	always_comb begin
		code_next = '0;
		code_next[$bits(data_word_t)-1:0] = enc_data;
		code_next[PAR_POS-1 -: HAM_BITS] = chk;
		// Overall parity makes the XOR of all 72 bits zero
		code_next[PAR_POS] = ^{chk, enc_data};
	end

	// One register stage, aligned with the write address
	always_ff @(posedge clk_ram_ctl or negedge arst_n) begin
		if (!arst_n)
			code <= '0;
		else
			code <= code_next;
	end

endmodule

`default_nettype wire

//--- hw/ecc_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_decoder import ingress_pkg::*; (
	input wire clk_ram_ctl,
	input wire arst_n,
	input wire in_valid,
	input wire code_word_t in_code,
	output logic out_valid,
	output data_word_t out_data,
	output logic corrected,
	output logic uncorrectable
);

	data_word_t data_in;
	data_word_t data_fixed;
	logic [HAM_BITS-1:0] syndrome;
	logic par_err;
	logic double_err;

	assign data_in = in_code[$bits(data_word_t)-1:0];

	// Syndrome gives the Hamming position of a single flipped bit
	assign syndrome = ham_check(data_in) ^ in_code[PAR_POS-1 -: HAM_BITS];
	assign par_err = ^in_code;

	// Nonzero syndrome with parity intact means two bits flipped
	assign double_err = !par_err && (syndrome != '0);

	// Flip the data bit at the syndrome position
	// Check bit or parity bit errors leave the data untouched
	always_comb begin
		data_fixed = data_in;
		for (int j = 0; j < $bits(data_word_t); j++) begin
			if (par_err && (32'(syndrome) == ham_pos(j)))
				data_fixed[j] = ~data_in[j];
		end
	end

	always_ff @(posedge clk_ram_ctl or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			corrected <= 1'b0;
			uncorrectable <= 1'b0;
		end else begin
			out_valid <= in_valid;
			// Flags only pulse with a valid word
			corrected <= in_valid && par_err;
			uncorrectable <= in_valid && double_err;
		end
	end

	always_ff @(posedge clk_ram_ctl) begin
		out_data <= data_fixed;
	end

endmodule

`default_nettype wire

//--- hw/port_ptr_table.sv
`timescale 1ns/1ps
`default_nettype none

module port_ptr_table #(
	parameter int NUM_PORTS = 4,
	parameter int PORT_WORDS = 256,
	localparam int PORT_BITS = $clog2(NUM_PORTS),
	localparam int PTR_BITS = $clog2(PORT_WORDS),
	localparam int ADDR_BITS = PORT_BITS + PTR_BITS
) (
	input wire clk_ram_ctl,
	input wire arst_n,
	input wire strobe,
	input wire [PORT_BITS-1:0] port,
	output logic addr_valid,
	output logic [ADDR_BITS-1:0] addr
);

	// One circular pointer per port region
	logic [PTR_BITS-1:0] ptr [NUM_PORTS];

	always_ff @(posedge clk_ram_ctl or negedge arst_n) begin
		if (!arst_n) begin
			addr_valid <= 1'b0;
			for (int i = 0; i < NUM_PORTS; i++)
				ptr[i] <= '0;
		end else begin
			addr_valid <= strobe;
			// Power-of-two region, so the pointer wraps on its own
			if (strobe)
				ptr[port] <= ptr[port] + 1'b1;
		end
	end

	// Port number forms the upper address bits
	always_ff @(posedge clk_ram_ctl) begin
		if (strobe)
			addr <= {port, ptr[port]};
	end

endmodule

`default_nettype wire

//--- hw/meta_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module meta_fifo #(
	parameter int WIDTH = 13,
	parameter int DEPTH = 16
) (
	input wire clk_ram_ctl,
	input wire arst_n,
	input wire push,
	input wire [WIDTH-1:0] wdata,
	input wire pop,
	output logic [WIDTH-1:0] rdata,
	output logic empty,
	output logic full
);

	localparam int IDX_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [IDX_BITS-1:0] wr_idx;
	logic [IDX_BITS-1:0] rd_idx;
	logic [CNT_BITS-1:0] count;

	// Show-ahead read, head entry always on rdata
	assign rdata = mem[rd_idx];
	assign empty = (count == '0);
	assign full = (count == CNT_BITS'(DEPTH));

	always_ff @(posedge clk_ram_ctl or negedge arst_n) begin
		if (!arst_n) begin
			wr_idx <= '0;
			rd_idx <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_idx <= (wr_idx == IDX_BITS'(DEPTH - 1)) ? '0 : wr_idx + 1'b1;
			if (pop)
				rd_idx <= (rd_idx == IDX_BITS'(DEPTH - 1)) ? '0 : rd_idx + 1'b1;
			// Occupancy
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_ram_ctl) begin
		if (push)
			mem[wr_idx] <= wdata;
	end

	a_no_overflow: assert property (@(posedge clk_ram_ctl) disable iff (!arst_n)
		push |-> !full)
		else $error("metadata push while full");

	a_no_underflow: assert property (@(posedge clk_ram_ctl) disable iff (!arst_n)
		pop |-> !empty)
		else $error("metadata pop while empty");

endmodule

`default_nettype wire

//--- hw/ingress_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module ingress_ctl import ingress_pkg::*; #(
	parameter int NUM_PORTS = 4,
	localparam int PORT_BITS = $clog2(NUM_PORTS),
	localparam int META_WIDTH = PORT_BITS + $bits(bytelen_t)
) (
	input wire clk_ram_ctl,
	input wire arst_n,

	// Port side
	input wire [NUM_PORTS-1:0] port_frame_ready,
	input wire [NUM_PORTS-1:0] port_mem_valid,
	input wire data_word_t port_mem_data [NUM_PORTS],
	input wire [NUM_PORTS-1:0] port_frame_done,
	input wire bytelen_t port_frame_bytelen [NUM_PORTS],
	output logic [NUM_PORTS-1:0] port_frame_start,

	// Write path toward encoder and write pointers
	output data_word_t enc_data,
	output logic wr_strobe,
	output logic [PORT_BITS-1:0] wr_port,

	// Metadata FIFO
	output logic meta_push,
	output logic [META_WIDTH-1:0] meta_wdata,
	output logic meta_pop,
	input wire [META_WIDTH-1:0] meta_rdata,
	input wire meta_empty,
	input wire meta_full,

	// Read path
	output logic rd_strobe,
	output logic [PORT_BITS-1:0] rd_port,
	input wire dec_valid,
	input wire data_word_t dec_data,
	input wire dec_corrected,
	input wire dec_uncorrectable,

	// Frame output stream
	output logic frame_valid,
	output logic frame_last,
	output data_word_t frame_data,
	output logic [PORT_BITS-1:0] frame_port,
	output bytelen_t frame_bytelen,
	output logic ecc_corrected,
	output logic ecc_uncorrectable
);

	////////////////////////////////////////////////////////////////////////////
	// Arbitration

	logic [PORT_BITS-1:0] rr_ptr;
	logic [PORT_BITS-1:0] next_port;
	logic next_valid;
	logic busy;
	logic [PORT_BITS-1:0] current_port;
	logic frame_done_now;
	logic grant;

	// Round-robin port first, else highest-numbered ready port
	always_comb begin
		next_port = rr_ptr;
		next_valid = 1'b0;
		if (port_frame_ready[rr_ptr]) begin
			next_valid = 1'b1;
		end else begin
			// Ascending scan, so the last hit is the highest port
			for (int i = 0; i < NUM_PORTS; i++) begin
				if (port_frame_ready[i]) begin
					next_port = PORT_BITS'(i);
					next_valid = 1'b1;
				end
			end
		end
	end

	assign frame_done_now = busy && port_frame_done[current_port];

	// New grant when idle or right after the current frame finishes
	assign grant = next_valid && !meta_full && (!busy || frame_done_now);

	always_ff @(posedge clk_ram_ctl or negedge arst_n) begin
		if (!arst_n) begin
			port_frame_start <= '0;
			busy <= 1'b0;
			current_port <= '0;
			rr_ptr <= '0;
			wr_strobe <= 1'b0;
		end else begin
			port_frame_start <= '0;
			if (frame_done_now)
				busy <= 1'b0;
			if (grant) begin
				port_frame_start[next_port] <= 1'b1;
				busy <= 1'b1;
				current_port <= next_port;
				// Pointer moves on every grant, modulo port count
				rr_ptr <= (rr_ptr == PORT_BITS'(NUM_PORTS - 1)) ? '0 : rr_ptr + 1'b1;
			end
			wr_strobe <= busy && port_mem_valid[current_port];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Write forwarding and metadata push

	// One register stage ahead of the encoder
	always_ff @(posedge clk_ram_ctl) begin
		enc_data <= port_mem_data[current_port];
		wr_port <= current_port;
	end

	// Metadata is visible to the readout one cycle after frame_done
	assign meta_push = frame_done_now;
	assign meta_wdata = {current_port, port_frame_bytelen[current_port]};

	////////////////////////////////////////////////////////////////////////////
	// Readout sequencer

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ISSUE,
		RD_DRAIN
	} rd_state_t;

	rd_state_t rd_state;
	wordlen_t rd_wordlen;
	wordlen_t issue_cnt;
	wordlen_t rx_cnt;
	logic [PORT_BITS-1:0] meta_port;
	bytelen_t meta_len;
	wordlen_t meta_wordlen;

	assign meta_port = meta_rdata[META_WIDTH-1 -: PORT_BITS];
	assign meta_len = meta_rdata[$bits(bytelen_t)-1:0];

	// Length in words, rounded up
	assign meta_wordlen = wordlen_t'((32'(meta_len) + WORD_BYTES - 1) / WORD_BYTES);

	assign meta_pop = (rd_state == RD_IDLE) && !meta_empty;
	assign rd_strobe = (rd_state == RD_ISSUE);
	assign rd_port = frame_port;

	always_ff @(posedge clk_ram_ctl or negedge arst_n) begin
		if (!arst_n) begin
			rd_state <= RD_IDLE;
			rd_wordlen <= '0;
			issue_cnt <= '0;
			rx_cnt <= '0;
			frame_port <= '0;
			frame_bytelen <= '0;
		end else begin
			// Count decoded words of the frame in flight
			if (dec_valid)
				rx_cnt <= frame_last ? '0 : rx_cnt + 1'b1;
			case (rd_state)
				RD_IDLE: begin
					if (!meta_empty) begin
						frame_port <= meta_port;
						frame_bytelen <= meta_len;
						rd_wordlen <= meta_wordlen;
						issue_cnt <= '0;
						rd_state <= RD_ISSUE;
					end
				end
				// One read strobe per cycle
				RD_ISSUE: begin
					issue_cnt <= issue_cnt + 1'b1;
					if (issue_cnt == rd_wordlen - 1'b1)
						rd_state <= RD_DRAIN;
				end
				// Wait for the last word to come back through the decoder
				RD_DRAIN: begin
					if (frame_last)
						rd_state <= RD_IDLE;
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	// Output stream straight off the decoder register
	assign frame_valid = dec_valid;
	assign frame_data = dec_data;
	assign frame_last = dec_valid && (rx_cnt == rd_wordlen - 1'b1);
	assign ecc_corrected = dec_corrected;
	assign ecc_uncorrectable = dec_uncorrectable;

	////////////////////////////////////////////////////////////////////////////
	// Checks

	// A grant only goes to a port that was ready when it was decided
	a_grant_ready: assert property (@(posedge clk_ram_ctl) disable iff (!arst_n)
		(port_frame_start & ~$past(port_frame_ready)) == '0)
		else $error("port_frame_start to a port that was not ready");

	// Every SRAM return belongs to a frame being read out
	a_no_stray_read: assert property (@(posedge clk_ram_ctl) disable iff (!arst_n)
		dec_valid |-> rd_state != RD_IDLE)
		else $error("decoded word while readout idle");

endmodule

`default_nettype wire

//--- hw/ingress_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ingress_fifo import ingress_pkg::*; #(
	parameter int NUM_PORTS = 4,
	parameter int PORT_WORDS = 256,
	parameter int META_DEPTH = 16,
	localparam int PORT_BITS = $clog2(NUM_PORTS),
	localparam int PTR_BITS = $clog2(PORT_WORDS),
	localparam int ADDR_BITS = PORT_BITS + PTR_BITS,
	localparam int META_WIDTH = PORT_BITS + $bits(bytelen_t)
) (
	input wire clk_ram_ctl,
	input wire arst_n,

	// Ingress ports
	input wire [NUM_PORTS-1:0] port_frame_ready,
	input wire [NUM_PORTS-1:0] port_mem_valid,
	input wire data_word_t port_mem_data [NUM_PORTS],
	input wire [NUM_PORTS-1:0] port_frame_done,
	input wire bytelen_t port_frame_bytelen [NUM_PORTS],
	output wire [NUM_PORTS-1:0] port_frame_start,

	// External SRAM
	output wire ram_wr_en,
	output wire [ADDR_BITS-1:0] ram_wr_addr,
	output wire code_word_t ram_wr_data,
	output wire ram_rd_en,
	output wire [ADDR_BITS-1:0] ram_rd_addr,
	input wire ram_rd_valid,
	input wire code_word_t ram_rd_data,

	// Frame output
	output wire frame_valid,
	output wire frame_last,
	output wire data_word_t frame_data,
	output wire [PORT_BITS-1:0] frame_port,
	output wire bytelen_t frame_bytelen,
	output wire ecc_corrected,
	output wire ecc_uncorrectable
);

	data_word_t enc_data;
	logic wr_strobe;
	logic [PORT_BITS-1:0] wr_port;
	logic meta_push;
	logic [META_WIDTH-1:0] meta_wdata;
	logic meta_pop;
	logic [META_WIDTH-1:0] meta_rdata;
	logic meta_empty;
	logic meta_full;
	logic rd_strobe;
	logic [PORT_BITS-1:0] rd_port;
	logic dec_valid;
	data_word_t dec_data;
	logic dec_corrected;
	logic dec_uncorrectable;

	////////////////////////////////////////////////////////////////////////////
	// Control

	ingress_ctl #(
		.NUM_PORTS(NUM_PORTS)
	) ctl (
		.clk_ram_ctl(clk_ram_ctl),
		.arst_n(arst_n),
		.port_frame_ready(port_frame_ready),
		.port_mem_valid(port_mem_valid),
		.port_mem_data(port_mem_data),
		.port_frame_done(port_frame_done),
		.port_frame_bytelen(port_frame_bytelen),
		.port_frame_start(port_frame_start),
		.enc_data(enc_data),
		.wr_strobe(wr_strobe),
		.wr_port(wr_port),
		.meta_push(meta_push),
		.meta_wdata(meta_wdata),
		.meta_pop(meta_pop),
		.meta_rdata(meta_rdata),
		.meta_empty(meta_empty),
		.meta_full(meta_full),
		.rd_strobe(rd_strobe),
		.rd_port(rd_port),
		.dec_valid(dec_valid),
		.dec_data(dec_data),
		.dec_corrected(dec_corrected),
		.dec_uncorrectable(dec_uncorrectable),
		.frame_valid(frame_valid),
		.frame_last(frame_last),
		.frame_data(frame_data),
		.frame_port(frame_port),
		.frame_bytelen(frame_bytelen),
		.ecc_corrected(ecc_corrected),
		.ecc_uncorrectable(ecc_uncorrectable)
	);

	////////////////////////////////////////////////////////////////////////////
	// SRAM write path

	ecc_encoder enc (
		.clk_ram_ctl(clk_ram_ctl),
		.arst_n(arst_n),
		.enc_data(enc_data),
		.code(ram_wr_data)
	);

	port_ptr_table #(
		.NUM_PORTS(NUM_PORTS),
		.PORT_WORDS(PORT_WORDS)
	) wr_ptrs (
		.clk_ram_ctl(clk_ram_ctl),
		.arst_n(arst_n),
		.strobe(wr_strobe),
		.port(wr_port),
		.addr_valid(ram_wr_en),
		.addr(ram_wr_addr)
	);

	meta_fifo #(
		.WIDTH(META_WIDTH),
		.DEPTH(META_DEPTH)
	) meta (
		.clk_ram_ctl(clk_ram_ctl),
		.arst_n(arst_n),
		.push(meta_push),
		.wdata(meta_wdata),
		.pop(meta_pop),
		.rdata(meta_rdata),
		.empty(meta_empty),
		.full(meta_full)
	);

	////////////////////////////////////////////////////////////////////////////
	// SRAM read path

	port_ptr_table #(
		.NUM_PORTS(NUM_PORTS),
		.PORT_WORDS(PORT_WORDS)
	) rd_ptrs (
		.clk_ram_ctl(clk_ram_ctl),
		.arst_n(arst_n),
		.strobe(rd_strobe),
		.port(rd_port),
		.addr_valid(ram_rd_en),
		.addr(ram_rd_addr)
	);

	ecc_decoder dec (
		.clk_ram_ctl(clk_ram_ctl),
		.arst_n(arst_n),
		.in_valid(ram_rd_valid),
		.in_code(ram_rd_data),
		.out_valid(dec_valid),
		.out_data(dec_data),
		.corrected(dec_corrected),
		.uncorrectable(dec_uncorrectable)
	);

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS = 10,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_ram_ctl,
	output logic arst_n
);

	// Free-running clock
	initial begin
		clk_ram_ctl = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_ram_ctl = ~clk_ram_ctl;
	end

	// Reset held for a fixed number of cycles, released between edges
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_ram_ctl);
		@(negedge clk_ram_ctl);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- verif/tb_ingress_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ingress_fifo import ingress_pkg::*; ();

	localparam int NUM_PORTS = 4;
	localparam int PORT_WORDS = 256;
	localparam int META_DEPTH = 16;
	localparam int PORT_BITS = $clog2(NUM_PORTS);
	localparam int PTR_BITS = $clog2(PORT_WORDS);
	localparam int ADDR_BITS = PORT_BITS + PTR_BITS;

	// Stimulus size
	localparam int FRAMES_PER_PORT = 6;
	localparam int TOTAL_FRAMES = NUM_PORTS * FRAMES_PER_PORT;
	localparam int MAX_BYTES = 200;

	// 24 frames of at most 25 words with gaps take about 1500 cycles
	localparam int TIMEOUT_CYCLES = 5000;

	// SRAM fault injection
	localparam int SINGLE_EVERY = 7;
	localparam int DOUBLE_READ = 60;

	logic clk_ram_ctl;
	logic arst_n;
	logic [NUM_PORTS-1:0] port_frame_ready;
	logic [NUM_PORTS-1:0] port_mem_valid;
	data_word_t port_mem_data [NUM_PORTS];
	logic [NUM_PORTS-1:0] port_frame_done;
	bytelen_t port_frame_bytelen [NUM_PORTS];
	logic [NUM_PORTS-1:0] port_frame_start;
	logic ram_wr_en;
	logic [ADDR_BITS-1:0] ram_wr_addr;
	code_word_t ram_wr_data;
	logic ram_rd_en;
	logic [ADDR_BITS-1:0] ram_rd_addr;
	logic ram_rd_valid;
	code_word_t ram_rd_data;
	logic frame_valid;
	logic frame_last;
	data_word_t frame_data;
	logic [PORT_BITS-1:0] frame_port;
	bytelen_t frame_bytelen;
	logic ecc_corrected;
	logic ecc_uncorrectable;

	// Port models
	int frame_len [NUM_PORTS][FRAMES_PER_PORT];
	bit port_active [NUM_PORTS];
	int sent_frames [NUM_PORTS];
	int word_idx [NUM_PORTS];
	int gap_left [NUM_PORTS];

	// SRAM model, read returns in order with their due cycle
	code_word_t sram [2**ADDR_BITS];
	code_word_t rd_data_q [$];
	int unsigned rd_due_q [$];
	int unsigned last_due;
	int rd_count;
	int flag_q [$];
	int unsigned cyc;

	// Write side reference
	int wr_port_q [$];
	int wr_ptr_model [NUM_PORTS];
	int exp_port;
	logic [ADDR_BITS-1:0] exp_addr;

	// Grant reference
	logic [NUM_PORTS-1:0] ready_q;
	int rr_model;
	int exp_grant;

	// Output side reference
	int rx_frame [NUM_PORTS];
	int frames_rx;
	int out_word;
	int out_words;
	int out_port;
	int out_frame;
	int out_len;
	int out_flag;
	int corr_seen;
	int double_seen;

	tb_clk_gen #(
		.PERIOD_NS(10),
		.RESET_CYCLES(8)
	) clk_gen (
		.clk_ram_ctl(clk_ram_ctl),
		.arst_n(arst_n)
	);

	ingress_fifo #(
		.NUM_PORTS(NUM_PORTS),
		.PORT_WORDS(PORT_WORDS),
		.META_DEPTH(META_DEPTH)
	) UUT (
		.clk_ram_ctl(clk_ram_ctl),
		.arst_n(arst_n),
		.port_frame_ready(port_frame_ready),
		.port_mem_valid(port_mem_valid),
		.port_mem_data(port_mem_data),
		.port_frame_done(port_frame_done),
		.port_frame_bytelen(port_frame_bytelen),
		.port_frame_start(port_frame_start),
		.ram_wr_en(ram_wr_en),
		.ram_wr_addr(ram_wr_addr),
		.ram_wr_data(ram_wr_data),
		.ram_rd_en(ram_rd_en),
		.ram_rd_addr(ram_rd_addr),
		.ram_rd_valid(ram_rd_valid),
		.ram_rd_data(ram_rd_data),
		.frame_valid(frame_valid),
		.frame_last(frame_last),
		.frame_data(frame_data),
		.frame_port(frame_port),
		.frame_bytelen(frame_bytelen),
		.ecc_corrected(ecc_corrected),
		.ecc_uncorrectable(ecc_uncorrectable)
	);

	////////////////////////////////////////////////////////////////////////////
	// Failure handling

	task automatic end_failed();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic halt_with(input string what);
		$display("%s", what);
		end_failed();
	endtask

	task automatic mismatch(input string test, input logic [71:0] expected,
			input logic [71:0] actual);
		$display("** Error in %s: expected %0h, actual %0h", test, expected, actual);
		end_failed();
	endtask

	// Fixed fields: marker, port, frame number, word index
	function automatic data_word_t frame_word(input int p, input int f, input int w);
		return {16'hC0DE, 16'(p), 16'(f), 16'(w)};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// SRAM and port models

	task automatic sram_step();
		code_word_t word;
		int unsigned due;
		int b0;
		int b1;
		int flag;
		ram_rd_valid = 1'b0;
		if (rd_due_q.size() > 0 && rd_due_q[0] == cyc) begin
			ram_rd_valid = 1'b1;
			ram_rd_data = rd_data_q.pop_front();
			void'(rd_due_q.pop_front());
		end
		if (ram_wr_en)
			sram[ram_wr_addr] = ram_wr_data;
		if (ram_rd_en) begin
			word = sram[ram_rd_addr];
			flag = 0;
			// Two distinct data bits on the designated read
			if (rd_count == DOUBLE_READ) begin
				b0 = $urandom % 64;
				b1 = (b0 + 1 + $urandom % 63) % 64;
				word[b0] = ~word[b0];
				word[b1] = ~word[b1];
				flag = 2;
			end else if (rd_count % SINGLE_EVERY == 2) begin
				// Any of the 72 bits, check and parity bits included
				b0 = $urandom % $bits(code_word_t);
				word[b0] = ~word[b0];
				flag = 1;
			end
			// Latency 1 to 5 cycles, never overtaking an older read
			due = cyc + 1 + $urandom % 5;
			if (due <= last_due)
				due = last_due + 1;
			last_due = due;
			rd_data_q.push_back(word);
			rd_due_q.push_back(due);
			flag_q.push_back(flag);
			rd_count++;
		end
	endtask

	task automatic port_step(input int p);
		int nwords;
		port_mem_valid[p] = 1'b0;
		port_frame_done[p] = 1'b0;
		if (port_active[p]) begin
			if (gap_left[p] > 0) begin
				gap_left[p]--;
			end else begin
				nwords = (frame_len[p][sent_frames[p]] + WORD_BYTES - 1) / WORD_BYTES;
				port_mem_valid[p] = 1'b1;
				port_mem_data[p] = frame_word(p, sent_frames[p], word_idx[p]);
				wr_port_q.push_back(p);
				if (word_idx[p] == nwords - 1) begin
					// Done and length ride with the final word
					port_frame_done[p] = 1'b1;
					port_frame_bytelen[p] = bytelen_t'(frame_len[p][sent_frames[p]]);
					port_active[p] = 1'b0;
					sent_frames[p]++;
				end else begin
					word_idx[p]++;
					gap_left[p] = $urandom % 3;
				end
			end
		end else if (port_frame_start[p]) begin
			port_frame_ready[p] = 1'b0;
			port_active[p] = 1'b1;
			word_idx[p] = 0;
			gap_left[p] = $urandom % 3;
		end else begin
			// Next frame offered one cycle after done
			port_frame_ready[p] = (sent_frames[p] < FRAMES_PER_PORT);
		end
	endtask

	// Single process owns all random draws and all DUT inputs
	initial begin : stimulus
		void'($urandom(83941));
		port_frame_ready = '0;
		port_mem_valid = '0;
		port_frame_done = '0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			port_mem_data[p] = '0;
			port_frame_bytelen[p] = '0;
			for (int f = 0; f < FRAMES_PER_PORT; f++)
				frame_len[p][f] = 1 + $urandom % MAX_BYTES;
		end
		ram_rd_valid = 1'b0;
		ram_rd_data = '0;
		@(posedge arst_n);
		forever begin
			@(negedge clk_ram_ctl);
			sram_step();
			for (int p = 0; p < NUM_PORTS; p++)
				port_step(p);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Cycle count and timeout

	always @(posedge clk_ram_ctl) begin
		cyc = cyc + 1;
		if (cyc >= TIMEOUT_CYCLES)
			halt_with("Timeout before all frames came out");
	end

	// Ready levels the arbiter saw in the previous cycle
	always @(posedge clk_ram_ctl)
		ready_q <= port_frame_ready;

	////////////////////////////////////////////////////////////////////////////
	// Checks

	a_start_onehot: assert property (@(posedge clk_ram_ctl) disable iff (!arst_n)
		$onehot0(port_frame_start))
		else halt_with("port_frame_start is not one-hot");

	// Each accepted port word reaches the SRAM exactly 2 cycles later
	a_wr_latency: assert property (@(posedge clk_ram_ctl) disable iff (!arst_n)
		ram_wr_en == $past(|port_mem_valid, 2))
		else halt_with("ram_wr_en not 2 cycles after an accepted port word");

	// Round-robin pointer port first, else highest ready port
	always @(negedge clk_ram_ctl) begin
		if (arst_n && port_frame_start != '0) begin
			exp_grant = rr_model;
			if (!ready_q[rr_model]) begin
				for (int i = 0; i < NUM_PORTS; i++)
					if (ready_q[i])
						exp_grant = i;
			end
			assert (ready_q[exp_grant])
				else halt_with("port_frame_start with no port ready");
			assert (port_frame_start == (NUM_PORTS'(1) << exp_grant))
				else mismatch("grant rule", NUM_PORTS'(1) << exp_grant, port_frame_start);
			rr_model = (rr_model + 1) % NUM_PORTS;
		end
	end

	// Write address walks the port region one word at a time
	always @(negedge clk_ram_ctl) begin
		if (arst_n && ram_wr_en) begin
			assert (wr_port_q.size() > 0)
				else halt_with("SRAM write without an accepted port word");
			exp_port = wr_port_q.pop_front();
			exp_addr = {PORT_BITS'(exp_port), PTR_BITS'(wr_ptr_model[exp_port])};
			assert (ram_wr_addr == exp_addr)
				else mismatch("write address", exp_addr, ram_wr_addr);
			wr_ptr_model[exp_port]++;
		end
	end

	// Output stream against the frames each port sent
	always @(negedge clk_ram_ctl) begin
		if (arst_n && frame_valid) begin
			assert (flag_q.size() > 0)
				else halt_with("Frame word with no SRAM read outstanding");
			out_flag = flag_q.pop_front();
			// First word selects that port's next frame
			if (out_word == 0) begin
				out_port = frame_port;
				assert (rx_frame[out_port] < FRAMES_PER_PORT)
					else halt_with("More frames came out than were sent");
				out_frame = rx_frame[out_port];
				out_len = frame_len[out_port][out_frame];
				out_words = (out_len + WORD_BYTES - 1) / WORD_BYTES;
			end
			assert (frame_port == out_port)
				else mismatch("frame port", out_port, frame_port);
			assert (frame_bytelen == out_len)
				else mismatch("frame length", out_len, frame_bytelen);
			// Word behind a double error is not checked
			if (out_flag != 2) begin
				assert (frame_data == frame_word(out_port, out_frame, out_word))
					else mismatch("frame data", frame_word(out_port, out_frame, out_word),
						frame_data);
			end
			assert (ecc_corrected == (out_flag == 1))
				else mismatch("single-bit correction", out_flag == 1, ecc_corrected);
			assert (ecc_uncorrectable == (out_flag == 2))
				else mismatch("double-bit detection", out_flag == 2, ecc_uncorrectable);
			assert (frame_last == (out_word == out_words - 1))
				else mismatch("frame_last position", out_word == out_words - 1, frame_last);
			if (out_flag == 1)
				corr_seen++;
			if (out_flag == 2)
				double_seen++;
			if (frame_last) begin
				rx_frame[out_port]++;
				frames_rx++;
				out_word = 0;
			end else begin
				out_word++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// End of run

	initial begin : main
		wait (frames_rx == TOTAL_FRAMES);
		repeat (8) @(negedge clk_ram_ctl);
		if (double_seen == 1 && corr_seen > 0 && flag_q.size() == 0 &&
				wr_port_q.size() == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			halt_with("ECC cases not reached or SRAM traffic left over at the end");
		end
	end

endmodule

`default_nettype wire

//--- list.f
hw/ingress_pkg.sv
hw/ecc_encoder.sv
hw/ecc_decoder.sv
hw/port_ptr_table.sv
hw/meta_fifo.sv
hw/ingress_ctl.sv
hw/ingress_fifo.sv
verif/tb_clk_gen.sv
verif/tb_ingress_fifo.sv

//--- Bender.yml
package:
  name: ingress_fifo

sources:
  - files:
      - hw/ingress_pkg.sv
      - hw/ecc_encoder.sv
      - hw/ecc_decoder.sv
      - hw/port_ptr_table.sv
      - hw/meta_fifo.sv
      - hw/ingress_ctl.sv
      - hw/ingress_fifo.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_ingress_fifo.sv
